//--- Makefile
TOP = cal_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --top-module $(TOP) -f cal_top.f

run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "TESTS PASSED" > /dev/null

clean:
	rm -rf obj_dir

//--- cal_top.f
hw/cal_pkg.sv
hw/cal_button_decode.sv
hw/cal_control.sv
hw/cal_operand_entry.sv
hw/cal_execute.sv
hw/cal_bin2bcd.sv
hw/cal_seven_seg.sv
hw/cal_top.sv
verif/cal_tb_sva.sv
verif/cal_tb.sv

//--- hw/cal_bin2bcd.sv
// Serial binary to BCD
`timescale 1ns/1ps

module cal_bin2bcd (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             cvt_start,
    input  cal_pkg::result_t result,
    output cal_pkg::bcd_t    bcd,
    output logic             cvt_done
);
    import cal_pkg::*;

    magnitude_t                    bin_q;
    bcd_t                          adj;
    logic [$clog2(BCD_CYCLES)-1:0] shift_cnt;
    logic                          busy;

    // add 3 to every digit of 5 or more before the shift
    always_comb begin
        adj = bcd;
        for (int i = 0; i < 6; i++) begin
            if (bcd[i] >= 4'd5) begin
                adj[i] = bcd[i] + 4'd3;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cvt_start) begin
            bcd   <= '0;
            bin_q <= result.valid ? result.magnitude : '0;
        end else if (busy) begin
            {bcd, bin_q} <= {adj, bin_q} << 1;
        end
    end

    // shift count, done after the last shift
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy      <= 1'b0;
            shift_cnt <= '0;
            cvt_done  <= 1'b0;
        end else begin
            cvt_done <= 1'b0;
            if (cvt_start) begin
                busy      <= 1'b1;
                shift_cnt <= '0;
            end else if (busy) begin
                shift_cnt <= shift_cnt + 1'b1;
                if (32'(shift_cnt) == BCD_CYCLES - 1) begin
                    busy     <= 1'b0;
                    cvt_done <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/cal_button_decode.sv
// Button debounce and qualify
`timescale 1ns/1ps

module cal_button_decode (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [cal_pkg::BUTTON_WIDTH-1:0] board_button,
    output cal_pkg::press_t                  press
);
    import cal_pkg::*;

    logic [BUTTON_WIDTH-1:0]            btn_sync;
    logic [BUTTON_WIDTH-1:0]            pressed;
    logic [BUTTON_WIDTH-1:0]            rise;
    logic [BUTTON_WIDTH-1:0]            qual;
    logic [$clog2(DEBOUNCE_CYCLES)-1:0] stable_cnt [BUTTON_WIDTH];

    // sync, then a level change must hold for DEBOUNCE_CYCLES
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            btn_sync <= '0;
            pressed  <= '0;
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            btn_sync <= board_button;
            for (int i = 0; i < BUTTON_WIDTH; i++) begin
                if (btn_sync[i] == pressed[i]) begin
                    stable_cnt[i] <= '0;
                end else if (32'(stable_cnt[i]) == DEBOUNCE_CYCLES - 1) begin
                    stable_cnt[i] <= '0;
                    pressed[i]    <= btn_sync[i];
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    // buttons about to turn pressed, lowest index wins
    always_comb begin
        logic lower;
        lower = 1'b0;
        for (int i = 0; i < BUTTON_WIDTH; i++) begin
            rise[i] = btn_sync[i] & ~pressed[i] & (32'(stable_cnt[i]) == DEBOUNCE_CYCLES - 1);
            qual[i] = rise[i] & ~lower;
            lower   = lower | rise[i];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            press <= '0;
        end else begin
            press.left  <= qual[BTN_LEFT];
            press.right <= qual[BTN_RIGHT];
            press.up    <= qual[BTN_UP];
            press.down  <= qual[BTN_DOWN];
            press.mid   <= qual[BTN_MID];
        end
    end

endmodule

//--- hw/cal_control.sv
// Calculator main sequencer
`timescale 1ns/1ps

module cal_control (
    input  logic                             clk,
    input  logic                             arst_n,
    input  cal_pkg::press_t                  press,
    input  logic [cal_pkg::SWITCH_WIDTH-1:0] board_switches,
    input  logic                             exec_done,
    input  cal_pkg::result_t                 result,
    input  logic                             cvt_done,
    output cal_pkg::ctrl_state_t             state,
    output logic                             capture_a,
    output logic                             capture_b,
    output logic                             entry_clear,
    output logic                             exec_start,
    output logic                             cvt_start,
    output cal_pkg::stage_t                  stage,
    output logic [cal_pkg::SWITCH_WIDTH-1:0] op_switches,
    output logic                             exe_done,
    output cal_pkg::stage_t                  display_stage
);
    import cal_pkg::*;

    stage_t stage_count;
    logic   last_stage;

    // short or invalid results fit on one screen
    assign stage_count = (!result.valid || result.magnitude < 20'd1000) ? 3'd1 : 3'd2;
    assign last_stage  = (stage == stage_count - 3'd1);

    assign capture_a   = (state == st_input_a) && press.mid;
    assign capture_b   = (state == st_input_b) && press.mid;
    assign entry_clear = (state == st_display) && press.mid && last_stage;

    assign exe_done      = (state == st_display);
    assign display_stage = stage + 3'd1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_input_a;
            stage       <= '0;
            op_switches <= '0;
            exec_start  <= 1'b0;
            cvt_start   <= 1'b0;
        end else begin
            exec_start <= capture_b;
            cvt_start  <= 1'b0;
            case (state)
                st_input_a: begin
                    if (press.mid) begin
                        state <= st_input_b;
                    end
                end
                st_input_b: begin
                    if (press.mid) begin
                        state       <= st_execute;
                        op_switches <= board_switches;
                    end
                end
                st_execute: begin
                    if (exec_done) begin
                        state     <= st_convert;
                        cvt_start <= 1'b1;
                    end
                end
                st_convert: begin
                    if (cvt_done) begin
                        state <= st_display;
                        stage <= '0;
                    end
                end
                st_display: begin
                    if (press.mid && last_stage) begin
                        state <= st_input_a;
                        stage <= '0;
                    end else if (press.mid) begin
                        stage <= stage + 3'd1;
                    end
                end
                default: state <= st_input_a;
            endcase
        end
    end

endmodule

//--- hw/cal_execute.sv
// Integer execute unit
`timescale 1ns/1ps

module cal_execute (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             exec_start,
    input  logic [cal_pkg::SWITCH_WIDTH-1:0] op_switches,
    input  cal_pkg::operand_t                operand_a,
    input  cal_pkg::operand_t                operand_b,
    output cal_pkg::result_t                 result,
    output logic                             exec_done
);
    import cal_pkg::*;

    op_sel_t            op_sel;
    logic signed [10:0] bin_a;
    logic signed [10:0] bin_b;
    logic               operands_ready;
    logic signed [20:0] value;

    // sign and three digits to two's complement
    function automatic logic signed [10:0] to_binary(operand_t op);
        logic [9:0] mag;
        mag = 10'(op.hundreds) * 10'd100 + 10'(op.tens) * 10'd10 + 10'(op.units);
        return op.sign ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
    endfunction

    // cycle 1, qualify op and convert
    always_ff @(posedge clk) begin
        if (exec_start) begin
            bin_a <= to_binary(operand_a);
            bin_b <= to_binary(operand_b);
            if (op_switches[0]) begin
                op_sel <= op_add;
            end else if (op_switches[1]) begin
                op_sel <= op_sub;
            end else if (op_switches[2]) begin
                op_sel <= op_mul;
            end else begin
                op_sel <= op_none;
            end
        end
    end

    always_comb begin
        case (op_sel)
            op_add:  value = bin_a + bin_b;
            op_sub:  value = bin_a - bin_b;
            op_mul:  value = bin_a * bin_b;
            default: value = '0;
        endcase
    end

    // cycle 2, sign and magnitude
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operands_ready <= 1'b0;
            exec_done      <= 1'b0;
            result         <= '0;
        end else begin
            operands_ready <= exec_start;
            exec_done      <= operands_ready;
            if (operands_ready) begin
                result.valid     <= (op_sel != op_none);
                result.negative  <= value[20];
                result.magnitude <= magnitude_t'(value[20] ? -value : value);
            end
        end
    end

endmodule

//--- hw/cal_operand_entry.sv
// Operand entry and capture
`timescale 1ns/1ps

module cal_operand_entry (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cal_pkg::press_t      press,
    input  cal_pkg::ctrl_state_t state,
    input  logic                 capture_a,
    input  logic                 capture_b,
    input  logic                 entry_clear,
    output cal_pkg::operand_t    cur_entry,
    output cal_pkg::operand_t    operand_a,
    output cal_pkg::operand_t    operand_b
);
    import cal_pkg::*;

    entry_pos_t pos;
    logic       editing;

    // one decimal step, wrapping 9 <-> 0
    function automatic digit_t step_digit(digit_t d, logic up);
        if (up) begin
            return (d == 4'd9) ? 4'd0 : d + 4'd1;
        end
        return (d == 4'd0) ? 4'd9 : d - 4'd1;
    endfunction

    assign editing = (state == st_input_a) || (state == st_input_b);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pos       <= pos_digit0;
            cur_entry <= '0;
        end else if (capture_a || entry_clear) begin
            pos       <= pos_digit0;
            cur_entry <= '0;
        end else if (editing) begin
            if (press.left) begin
                if (pos != pos_sign) begin
                    pos <= pos.next();
                end
            end else if (press.right) begin
                if (pos != pos_digit0) begin
                    pos <= pos.prev();
                end
            end else if (press.up || press.down) begin
                case (pos)
                    pos_digit0: cur_entry.units    <= step_digit(cur_entry.units, press.up);
                    pos_digit1: cur_entry.tens     <= step_digit(cur_entry.tens, press.up);
                    pos_digit2: cur_entry.hundreds <= step_digit(cur_entry.hundreds, press.up);
                    default:    cur_entry.sign     <= ~cur_entry.sign;
                endcase
            end
        end
    end

    // operand registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            operand_a <= '0;
            operand_b <= '0;
        end else begin
            if (capture_a) begin
                operand_a <= cur_entry;
            end
            if (capture_b) begin
                operand_b <= cur_entry;
            end
        end
    end

endmodule

//--- hw/cal_pkg.sv
// Calculator common types
package cal_pkg;

    localparam int BUTTON_WIDTH = 5;
    localparam int BTN_LEFT = 0;
    localparam int BTN_RIGHT = 1;
    localparam int BTN_UP = 2;
    localparam int BTN_DOWN = 3;
    localparam int BTN_MID = 4;

    // switch bit 0 add, bit 1 sub, bit 2 mul
    localparam int SWITCH_WIDTH = 3;

    localparam int DEBOUNCE_CYCLES = 4;
    localparam int SCAN_DIV = 4;
    localparam int BCD_CYCLES = 20;

    typedef logic [3:0] digit_t;
    typedef logic [19:0] magnitude_t;
    typedef logic [2:0] stage_t;
    typedef digit_t [5:0] bcd_t;

    localparam digit_t CODE_BLANK = 4'ha;
    localparam digit_t CODE_MINUS = 4'hb;

    typedef struct packed {
        logic   sign;
        digit_t hundreds;
        digit_t tens;
        digit_t units;
    } operand_t;

    // bit order follows the BTN_* indices
    typedef struct packed {
        logic mid;
        logic down;
        logic up;
        logic right;
        logic left;
    } press_t;

    typedef struct packed {
        logic       negative;
        logic       valid;
        magnitude_t magnitude;
    } result_t;

    typedef enum logic [1:0] {op_add, op_sub, op_mul, op_none} op_sel_t;

    typedef enum logic [2:0] {
        st_input_a,
        st_input_b,
        st_execute,
        st_convert,
        st_display
    } ctrl_state_t;

    typedef enum logic [1:0] {pos_digit0, pos_digit1, pos_digit2, pos_sign} entry_pos_t;

    // active-low segments, codes 0-9 then blank and minus
    localparam logic [7:0] SEG_TABLE [12] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001, 8'b1111_1111, 8'b1111_1101
    };

endpackage

//--- hw/cal_seven_seg.sv
// Seven-segment display driver
`timescale 1ns/1ps

module cal_seven_seg (
    input  logic                 clk,
    input  logic                 arst_n,
    input  cal_pkg::ctrl_state_t state,
    input  cal_pkg::stage_t      stage,
    input  cal_pkg::operand_t    cur_entry,
    input  cal_pkg::result_t     result,
    input  cal_pkg::bcd_t        bcd,
    output logic [3:0]           digit_ctrl,
    output logic [7:0]           digit_seg
);
    import cal_pkg::*;

    logic [$clog2(SCAN_DIV)-1:0] scan_cnt;
    logic [1:0]                  pos_cnt;
    digit_t [3:0]                shown;
    digit_t                      code;
    digit_t                      sign_code;
    logic                        high_part;
    logic                        blank_all;

    // scan divider, position 0 is rightmost
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scan_cnt <= '0;
            pos_cnt  <= '0;
        end else if (32'(scan_cnt) == SCAN_DIV - 1) begin
            scan_cnt <= '0;
            pos_cnt  <= pos_cnt + 2'd1;
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    always_comb begin
        sign_code = result.negative ? CODE_MINUS : CODE_BLANK;
        high_part = (bcd[5] != 4'd0) || (bcd[4] != 4'd0) || (bcd[3] != 4'd0);
        if (state == st_input_a || state == st_input_b) begin
            shown = {cur_entry.sign ? CODE_MINUS : CODE_BLANK,
                     cur_entry.hundreds, cur_entry.tens, cur_entry.units};
        end else if (stage == 3'd0 && high_part) begin
            shown = {sign_code, bcd[5], bcd[4], bcd[3]};
        end else if (stage == 3'd0) begin
            shown = {sign_code, bcd[2], bcd[1], bcd[0]};
        end else begin
            // low half of a two-stage result
            shown = {CODE_BLANK, bcd[2], bcd[1], bcd[0]};
        end
    end

    assign blank_all = (state == st_execute) || (state == st_convert) ||
                       ((state == st_display) && !result.valid);
    assign digit_ctrl = blank_all ? 4'b1111 : ~(4'b0001 << pos_cnt);

    assign code      = shown[pos_cnt];
    assign digit_seg = (code <= CODE_MINUS) ? SEG_TABLE[code] : SEG_TABLE[CODE_BLANK];

endmodule

//--- hw/cal_top.sv
// Calculator top level
`timescale 1ns/1ps

module cal_top (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [cal_pkg::BUTTON_WIDTH-1:0] board_button,
    input  logic [cal_pkg::SWITCH_WIDTH-1:0] board_switches,
    output logic [3:0]                       digit_ctrl,
    output logic [7:0]                       digit_seg,
    output logic                             exe_done,
    output cal_pkg::stage_t                  display_stage
);
    import cal_pkg::*;

    press_t                  press;
    ctrl_state_t             state;
    logic                    capture_a;
    logic                    capture_b;
    logic                    entry_clear;
    logic                    exec_start;
    logic                    cvt_start;
    stage_t                  stage;
    logic [SWITCH_WIDTH-1:0] op_switches;
    operand_t                cur_entry;
    operand_t                operand_a;
    operand_t                operand_b;
    result_t                 result;
    logic                    exec_done;
    bcd_t                    bcd;
    logic                    cvt_done;

    // decode stage
    cal_button_decode u_button_decode (
        .clk          (clk),
        .arst_n       (arst_n),
        .board_button (board_button),
        .press        (press)
    );

    cal_control u_control (
        .clk            (clk),
        .arst_n         (arst_n),
        .press          (press),
        .board_switches (board_switches),
        .exec_done      (exec_done),
        .result         (result),
        .cvt_done       (cvt_done),
        .state          (state),
        .capture_a      (capture_a),
        .capture_b      (capture_b),
        .entry_clear    (entry_clear),
        .exec_start     (exec_start),
        .cvt_start      (cvt_start),
        .stage          (stage),
        .op_switches    (op_switches),
        .exe_done       (exe_done),
        .display_stage  (display_stage)
    );

    cal_operand_entry u_operand_entry (
        .clk         (clk),
        .arst_n      (arst_n),
        .press       (press),
        .state       (state),
        .capture_a   (capture_a),
        .capture_b   (capture_b),
        .entry_clear (entry_clear),
        .cur_entry   (cur_entry),
        .operand_a   (operand_a),
        .operand_b   (operand_b)
    );

    // execute stage
    cal_execute u_execute (
        .clk         (clk),
        .arst_n      (arst_n),
        .exec_start  (exec_start),
        .op_switches (op_switches),
        .operand_a   (operand_a),
        .operand_b   (operand_b),
        .result      (result),
        .exec_done   (exec_done)
    );

    // result stage
    cal_bin2bcd u_bin2bcd (
        .clk       (clk),
        .arst_n    (arst_n),
        .cvt_start (cvt_start),
        .result    (result),
        .bcd       (bcd),
        .cvt_done  (cvt_done)
    );

    cal_seven_seg u_seven_seg (
        .clk        (clk),
        .arst_n     (arst_n),
        .state      (state),
        .stage      (stage),
        .cur_entry  (cur_entry),
        .result     (result),
        .bcd        (bcd),
        .digit_ctrl (digit_ctrl),
        .digit_seg  (digit_seg)
    );

endmodule

//--- verif/cal_tb.sv
// Calculator testbench
`timescale 1ns/1ps

module cal_tb;
    import cal_pkg::*;

    typedef digit_t [3:0] screen_t;

    localparam int CLK_PERIOD   = 40;
    localparam int HOLD_CYCLES  = DEBOUNCE_CYCLES + 2;
    localparam int PRESS_CYCLES = 2 * HOLD_CYCLES;
    localparam int NUM_EDITS    = 40;
    localparam int NUM_OPS      = 12;
    // at most about 50 presses per operation
    localparam int MAX_PRESSES  = NUM_EDITS + (NUM_OPS + 3) * 50 + 20;
    localparam int WATCHDOG_NS  = MAX_PRESSES * 2 * PRESS_CYCLES * CLK_PERIOD + 100000;

    localparam logic [7:0] SEGMENTS [12] = '{
        8'b0000_0011, 8'b1001_1111, 8'b0010_0101, 8'b0000_1101,
        8'b1001_1001, 8'b0100_1001, 8'b0100_0001, 8'b0001_1111,
        8'b0000_0001, 8'b0001_1001, 8'b1111_1111, 8'b1111_1101
    };

    logic                    clk;
    logic                    arst_n;
    logic [BUTTON_WIDTH-1:0] board_button;
    logic [SWITCH_WIDTH-1:0] board_switches;
    logic [3:0]              digit_ctrl;
    logic [7:0]              digit_seg;
    logic                    exe_done;
    stage_t                  display_stage;

    logic [15:0] lfsr;
    int          errors;
    int          test_errors;
    int          tests_failed;
    // entry model
    int          ent_pos;
    int          ent_digit [3];
    logic        ent_sign;

    cal_top cal_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .board_button   (board_button),
        .board_switches (board_switches),
        .digit_ctrl     (digit_ctrl),
        .digit_seg      (digit_seg),
        .exe_done       (exe_done),
        .display_stage  (display_stage)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // galois lfsr, taps 16 14 13 11
    function automatic int take_bits(int n);
        int   value;
        logic out;
        value = 0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ 16'hb400;
            end
            value = (value << 1) | int'(out);
        end
        return value;
    endfunction

    function automatic digit_t seg_to_code(logic [7:0] seg);
        digit_t code;
        code = 4'hf;
        for (int i = 0; i < 12; i++) begin
            if (SEGMENTS[i] == seg) begin
                code = digit_t'(i);
            end
        end
        return code;
    endfunction

    function automatic void clear_entry();
        ent_pos  = 0;
        ent_sign = 1'b0;
        for (int i = 0; i < 3; i++) begin
            ent_digit[i] = 0;
        end
    endfunction

    // position saturates, digits wrap, sign toggles
    function automatic void apply_entry(int btn);
        if (btn == BTN_LEFT && ent_pos < 3) begin
            ent_pos++;
        end else if (btn == BTN_RIGHT && ent_pos > 0) begin
            ent_pos--;
        end else if ((btn == BTN_UP || btn == BTN_DOWN) && ent_pos == 3) begin
            ent_sign = ~ent_sign;
        end else if (btn == BTN_UP) begin
            ent_digit[ent_pos] = (ent_digit[ent_pos] + 1) % 10;
        end else if (btn == BTN_DOWN) begin
            ent_digit[ent_pos] = (ent_digit[ent_pos] + 9) % 10;
        end
    endfunction

    function automatic screen_t entry_screen();
        screen_t s;
        for (int i = 0; i < 3; i++) begin
            s[i] = digit_t'(ent_digit[i]);
        end
        s[3] = ent_sign ? CODE_MINUS : CODE_BLANK;
        return s;
    endfunction

    function automatic screen_t result_screen(int value, int stage_idx);
        int      mag;
        int      rest;
        digit_t  d [6];
        digit_t  sign_code;
        mag       = (value < 0) ? -value : value;
        rest      = mag;
        sign_code = (value < 0) ? CODE_MINUS : CODE_BLANK;
        for (int i = 0; i < 6; i++) begin
            d[i] = digit_t'(rest % 10);
            rest = rest / 10;
        end
        if (mag < 1000) begin
            return {sign_code, d[2], d[1], d[0]};
        end else if (stage_idx == 0) begin
            return {sign_code, d[5], d[4], d[3]};
        end
        return {CODE_BLANK, d[2], d[1], d[0]};
    endfunction

    task automatic note_error(string msg);
        errors++;
        test_errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic check_digit(digit_t got, digit_t expected, string what);
        if (got !== expected) begin
            note_error($sformatf("%s got %h expected %h", what, got, expected));
        end
    endtask

    task automatic check_stage(stage_t got, stage_t expected, string what);
        if (got !== expected) begin
            note_error($sformatf("%s got %0d expected %0d", what, got, expected));
        end
    endtask

    task automatic check_bit(logic got, logic expected, string what);
        if (got !== expected) begin
            note_error($sformatf("%s got %b expected %b", what, got, expected));
        end
    endtask

    task automatic finish_test(int num, string name);
        if (test_errors == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d failed checks", num, name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic press_buttons(logic [BUTTON_WIDTH-1:0] mask);
        @(posedge clk);
        board_button <= mask;
        repeat (HOLD_CYCLES) @(posedge clk);
        board_button <= '0;
        repeat (HOLD_CYCLES) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic edit(int btn);
        logic [BUTTON_WIDTH-1:0] mask;
        mask      = '0;
        mask[btn] = 1'b1;
        press_buttons(mask);
        apply_entry(btn);
    endtask

    // sample each position in the middle of its scan window
    task automatic read_display(output screen_t shown);
        logic [3:0] pattern;
        for (int p = 0; p < 4; p++) begin
            pattern = ~(4'b0001 << p);
            @(negedge clk);
            while (digit_ctrl == pattern) begin
                @(negedge clk);
            end
            while (digit_ctrl != pattern) begin
                @(negedge clk);
            end
            repeat (SCAN_DIV / 2) @(negedge clk);
            shown[p] = seg_to_code(digit_seg);
        end
    endtask

    task automatic check_screen(screen_t expected, string what);
        screen_t got;
        read_display(got);
        for (int p = 0; p < 4; p++) begin
            check_digit(got[p], expected[p], $sformatf("%s position %0d", what, p));
        end
    endtask

    task automatic check_blank();
        repeat (8 * SCAN_DIV) begin
            @(negedge clk);
            check_digit(digit_t'(digit_ctrl), 4'b1111, "digit_ctrl on invalid result");
        end
    endtask

    task automatic enter_operand(int value);
        int mag;
        int target;
        int steps;
        mag = (value < 0) ? -value : value;
        for (int p = 0; p < 3; p++) begin
            target = (mag / (10 ** p)) % 10;
            while (ent_pos > p) begin
                edit(BTN_RIGHT);
            end
            while (ent_pos < p) begin
                edit(BTN_LEFT);
            end
            steps = (target - ent_digit[p] + 10) % 10;
            if (steps <= 5) begin
                repeat (steps) edit(BTN_UP);
            end else begin
                repeat (10 - steps) edit(BTN_DOWN);
            end
        end
        if (ent_sign != (value < 0)) begin
            while (ent_pos < 3) begin
                edit(BTN_LEFT);
            end
            edit(BTN_UP);
        end
    endtask

    task automatic run_operation(int a, int b, logic [SWITCH_WIDTH-1:0] sw);
        int   value;
        logic valid;
        int   stages;
        int   cycles;
        @(posedge clk);
        board_switches <= sw;
        enter_operand(a);
        check_screen(entry_screen(), "operand a entry");
        edit(BTN_MID);
        clear_entry();
        enter_operand(b);
        check_screen(entry_screen(), "operand b entry");
        edit(BTN_MID);
        // lowest switch wins
        valid = 1'b1;
        value = 0;
        if (sw[0]) begin
            value = a + b;
        end else if (sw[1]) begin
            value = a - b;
        end else if (sw[2]) begin
            value = a * b;
        end else begin
            valid = 1'b0;
        end
        cycles = 0;
        while (!exe_done && cycles < 4 * BCD_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (!exe_done) begin
            errors++;
            test_errors++;
            $display("ERROR at %0t ns: exe_done never rose after the operation", $time);
        end
        stages = (valid && (value >= 1000 || value <= -1000)) ? 2 : 1;
        for (int s = 0; s < stages; s++) begin
            check_bit(exe_done, 1'b1, "exe_done in display");
            check_stage(display_stage, stage_t'(s + 1), "display_stage");
            if (valid) begin
                check_screen(result_screen(value, s), $sformatf("result stage %0d", s));
            end else begin
                check_blank();
            end
            edit(BTN_MID);
        end
        clear_entry();
        check_bit(exe_done, 1'b0, "exe_done after return");
        check_stage(display_stage, 3'd1, "display_stage after return");
        check_screen(entry_screen(), "cleared entry");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        int a;
        int b;
        logic [SWITCH_WIDTH-1:0] sw;
        lfsr           = 16'd81;
        errors         = 0;
        test_errors    = 0;
        tests_failed   = 0;
        arst_n         = 1'b0;
        board_button   = '0;
        board_switches = '0;
        clear_entry();
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        @(negedge clk);
        check_bit(exe_done, 1'b0, "exe_done after reset");
        check_stage(display_stage, 3'd1, "display_stage after reset");
        check_screen(entry_screen(), "reset display");
        finish_test(1, "reset state");

        for (int i = 0; i < NUM_EDITS; i++) begin
            edit(take_bits(2));
            check_screen(entry_screen(), $sformatf("edit %0d", i));
        end
        finish_test(2, "operand editing");

        for (int i = 0; i < NUM_OPS; i++) begin
            a  = (take_bits(10) % 1000) * (take_bits(1) == 1 ? -1 : 1);
            b  = (take_bits(10) % 1000) * (take_bits(1) == 1 ? -1 : 1);
            sw = SWITCH_WIDTH'(take_bits(3));
            if (sw == '0) begin
                sw = 3'b001;
            end
            run_operation(a, b, sw);
        end
        finish_test(3, "random operations");

        run_operation(take_bits(9), -take_bits(9), 3'b000);
        finish_test(4, "no operation selected");

        run_operation(999, -999, 3'b100);
        finish_test(5, "return from last stage");

        // left beats up, right beats down
        press_buttons(5'b00101);
        apply_entry(BTN_LEFT);
        check_screen(entry_screen(), "left with up");
        edit(BTN_UP);
        check_screen(entry_screen(), "up after left");
        press_buttons(5'b01010);
        apply_entry(BTN_RIGHT);
        check_screen(entry_screen(), "right with down");
        edit(BTN_DOWN);
        check_screen(entry_screen(), "down after right");
        finish_test(6, "button priority");

        $display("failing tests %0d of 6, failed checks %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/cal_tb_sva.sv
// Sequencer assertions
`timescale 1ns/1ps

module cal_tb_sva (
    input logic                 clk,
    input logic                 arst_n,
    input cal_pkg::press_t      press,
    input logic                 cvt_done,
    input cal_pkg::ctrl_state_t state,
    input cal_pkg::stage_t      stage,
    input cal_pkg::result_t     result,
    input logic                 exe_done,
    input logic                 capture_a,
    input logic                 capture_b,
    input logic                 entry_clear,
    input logic                 exec_start,
    input logic                 cvt_start
);
    import cal_pkg::*;

    logic [4:0] strobes;
    stage_t     stage_count;
    logic       leave_display;

    assign strobes     = {capture_a, capture_b, entry_clear, exec_start, cvt_start};
    assign stage_count = (result.valid && result.magnitude >= 20'd1000) ? 3'd2 : 3'd1;
    // mid on the last stage ends the display
    assign leave_display = press.mid && (stage == stage_count - 3'd1);

    // display entered on cvt_done and left on a last-stage mid
    a_exe_done_rise: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(exe_done) == $past(cvt_done))
        else $error("exe_done did not rise with the end of the conversion");

    a_exe_done_fall: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(exe_done) == $past(exe_done && leave_display))
        else $error("exe_done did not fall with a mid press on the last stage");

    // no strobe may be high two cycles in a row
    a_strobe_width: assert property (@(posedge clk) disable iff (!arst_n)
        (strobes != '0) |=> ((strobes & $past(strobes)) == '0))
        else $error("a sequencer strobe lasted more than one cycle");

    a_stage_range: assert property (@(posedge clk) disable iff (!arst_n)
        (state == st_display) |-> (stage < stage_count))
        else $error("display stage reached the stage count");

endmodule

bind cal_control cal_tb_sva control_checks (
    .clk         (clk),
    .arst_n      (arst_n),
    .press       (press),
    .cvt_done    (cvt_done),
    .state       (state),
    .stage       (stage),
    .result      (result),
    .exe_done    (exe_done),
    .capture_a   (capture_a),
    .capture_b   (capture_b),
    .entry_clear (entry_clear),
    .exec_start  (exec_start),
    .cvt_start   (cvt_start)
);
